//--- hdl/coleco_consts.svh
`ifndef COLECO_CONSTS_SVH
`define COLECO_CONSTS_SVH

// ------------------------------------------------------------
// Memory widths
// ------------------------------------------------------------

// CPU RAM address, 32k at most with SGM
`define RAM_AW 15

// Cartridge download address
`define DL_AW 16

// ------------------------------------------------------------
// SG-1000 cartridge checksum window
// ------------------------------------------------------------

// First byte of the 2xxx-3xxx block
`define SG_CHK_START 16'h2000

// Upper three address bits of 2xxx-3xxx
`define SG_CHK_PAGE 3'b001

// ------------------------------------------------------------
// Controller defaults
// ------------------------------------------------------------

`define SPIN_DIV_BITS 16

// All pins released, no key pressed
`define KEY_NONE 4'b1111

`endif

//--- hdl/coleco_ctrl_pkg.sv
package coleco_ctrl_pkg;

    // Host joystick word, active high, bit 0 is right
    typedef struct packed {
        logic [1:0] spare;
        logic       fire2;
        logic       fire1;
        logic       up;
        logic       down;
        logic       left;
        logic       right;
    } joy_word_t;

    // Strobe selects from the console
    typedef struct packed {
        logic p5;
        logic p8;
    } ctrl_sel_t;

    // Joystick directions on pins 1..4, active low
    typedef struct packed {
        logic up_n;
        logic down_n;
        logic left_n;
        logic right_n;
    } pad_dirs_t;

    // Pins 1..4 carry a keypad code or four directions
    typedef union packed {
        logic [3:0] key_code;
        pad_dirs_t  dirs;
    } pad_lines_u;

    // One controller port, all pins active low
    typedef struct packed {
        pad_lines_u lines;
        logic       p6;
        logic       p7;
        logic       p9;
    } port_pins_t;

    // Registered controller inputs for one port
    typedef struct packed {
        joy_word_t   joy;
        logic [15:0] ps2_keys;
        logic [4:0]  ps2_joy;
        logic        spin_en;
    } pad_in_t;

endpackage

//--- hdl/coleco_mem_pkg.sv
`include "coleco_consts.svh"

package coleco_mem_pkg;

    // Loader write port
    // wr is a one-cycle strobe, active is a level over the whole download
    typedef struct packed {
        logic                active;
        logic                wr;
        logic [`DL_AW-1:0]   addr;
        logic [7:0]          data;
    } dl_write_t;

    // CPU RAM request from the console core
    typedef struct packed {
        logic [`RAM_AW-1:0]  addr;
        logic                ce_n;
        logic                we_n;
    } ram_req_t;

    // RAM size selection
    // Value 3 is treated the same as SGM
    typedef enum logic [1:0] {
        RAM_1K  = 2'd0,
        RAM_8K  = 2'd1,
        RAM_SGM = 2'd2
    } ram_size_e;

endpackage

//--- hdl/pad_input_stage.sv
`include "coleco_consts.svh"

module pad_input_stage
    import coleco_ctrl_pkg::*;
#(
    parameter int spin_div_bits = `SPIN_DIV_BITS
) (
    input  logic          clk_sys,
    input  logic          reset,
    input  joy_word_t     joy0_i,
    input  joy_word_t     joy1_i,
    input  logic [15:0]   ps2_keys_i,
    input  logic [4:0]    ps2_joy_i,
    input  logic          joy_swap_i,
    output pad_in_t [1:0] pad_o
);

    joy_word_t                joy_a_q;
    joy_word_t                joy_b_q;
    logic [15:0]              keys_q;
    logic [4:0]               ps2_joy_q;
    logic [spin_div_bits-1:0] div_cnt;
    logic                     spin_en_q;

    // Host inputs, swap applied on the way in
    always_ff @(posedge clk_sys) begin
        joy_a_q   <= joy_swap_i ? joy1_i : joy0_i;
        joy_b_q   <= joy_swap_i ? joy0_i : joy1_i;
        keys_q    <= ps2_keys_i;
        ps2_joy_q <= ps2_joy_i;
    end

    // Spinner step rate, one pulse per counter wrap
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            div_cnt   <= '0;
            spin_en_q <= 1'b0;
        end else begin
            div_cnt   <= div_cnt + 1'b1;
            spin_en_q <= (div_cnt == '0);
        end
    end

    // Keyboard is shared by both ports
    assign pad_o[0] = '{joy: joy_a_q, ps2_keys: keys_q, ps2_joy: ps2_joy_q, spin_en: spin_en_q};
    assign pad_o[1] = '{joy: joy_b_q, ps2_keys: keys_q, ps2_joy: ps2_joy_q, spin_en: spin_en_q};

endmodule

//--- hdl/ctrl_port_encoder.sv
`include "coleco_consts.svh"

module ctrl_port_encoder
    import coleco_ctrl_pkg::*;
(
    input  logic       clk_sys,
    input  logic       reset,
    input  pad_in_t    pad_i,
    input  ctrl_sel_t  sel_i,
    input  logic       spinner_on_i,
    output port_pins_t pins_o
);

    // Keys in priority order 1..9, 0, *, #
    localparam int KEY_BIT [12] = '{13, 7, 12, 2, 3, 14, 5, 1, 11, 10, 9, 6};

    // Pin 1..4 codes, same order as KEY_BIT
    localparam logic [3:0] KEY_CODE [12] = '{
        4'b1110,
        4'b1101,
        4'b0110,
        4'b0001,
        4'b1001,
        4'b0111,
        4'b1100,
        4'b1000,
        4'b1011,
        4'b0011,
        4'b1010,
        4'b0101
    };

    logic [3:0] key_code;
    pad_lines_u lines;
    logic       p6;
    logic [1:0] quad_q;
    logic [1:0] quad_next;

    // ------------------------------------------------------------
    // Keypad and joystick pins
    // ------------------------------------------------------------

    // Walk from lowest priority up so the highest one wins
    always_comb begin
        key_code = `KEY_NONE;
        for (int i = 11; i >= 0; i--) begin
            if (pad_i.ps2_keys[KEY_BIT[i]]) begin
                key_code = KEY_CODE[i];
            end
        end
    end

    always_comb begin
        lines.key_code = `KEY_NONE;
        p6             = 1'b1;
        if (!sel_i.p5 && sel_i.p8) begin
            // Keypad and right button
            lines.key_code = key_code;
            p6             = ~(pad_i.ps2_keys[0] | pad_i.joy.fire2);
        end else if (sel_i.p5 && !sel_i.p8) begin
            // Joystick and left button
            lines.dirs.up_n    = ~(pad_i.ps2_joy[0] | pad_i.joy.up);
            lines.dirs.down_n  = ~(pad_i.ps2_joy[1] | pad_i.joy.down);
            lines.dirs.left_n  = ~(pad_i.ps2_joy[2] | pad_i.joy.left);
            lines.dirs.right_n = ~(pad_i.ps2_joy[3] | pad_i.joy.right);
            p6                 = ~(pad_i.ps2_joy[4] | pad_i.joy.fire1);
        end
    end

    // ------------------------------------------------------------
    // Spinner quadrature on {p7, p9}
    // ------------------------------------------------------------

    always_comb begin
        quad_next = quad_q;
        if (pad_i.joy.left) begin
            case (quad_q)
                2'b00:   quad_next = 2'b01;
                2'b01:   quad_next = 2'b11;
                2'b11:   quad_next = 2'b10;
                default: quad_next = 2'b00;
            endcase
        end else if (pad_i.joy.right) begin
            case (quad_q)
                2'b00:   quad_next = 2'b10;
                2'b10:   quad_next = 2'b11;
                2'b11:   quad_next = 2'b01;
                default: quad_next = 2'b00;
            endcase
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset || !spinner_on_i) begin
            quad_q <= 2'b11;
        end else if (pad_i.spin_en) begin
            quad_q <= quad_next;
        end
    end

    assign pins_o.lines = lines;
    assign pins_o.p6    = p6;
    assign pins_o.p7    = quad_q[1];
    assign pins_o.p9    = quad_q[0];

endmodule

//--- hdl/sg_cart_probe.sv
`include "coleco_consts.svh"

module sg_cart_probe
    import coleco_mem_pkg::*;
(
    input  logic      clk_sys,
    input  logic      reset,
    input  dl_write_t dl_i,
    input  logic      sg1000_i,
    output logic      flat_map_o
);

    logic       active_q;
    logic [7:0] chksum;
    logic       flat_map;

    // AND of all bytes in 2xxx-3xxx
    // An all-FF block marks carts that want the flat RAM map
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            active_q <= 1'b0;
            chksum   <= '0;
            flat_map <= 1'b0;
        end else begin
            active_q <= dl_i.active;

            if (sg1000_i && dl_i.active) begin
                // New download starts
                if (!active_q) begin
                    chksum   <= '0;
                    flat_map <= 1'b0;
                end
                if (dl_i.wr) begin
                    if (dl_i.addr == `SG_CHK_START) begin
                        chksum <= dl_i.data;
                    end else if (dl_i.addr[`DL_AW-1 -: 3] == `SG_CHK_PAGE) begin
                        chksum <= chksum & dl_i.data;
                    end
                end
            end

            if (sg1000_i && !dl_i.active && chksum == 8'hFF) begin
                flat_map <= 1'b1;
            end
        end
    end

    assign flat_map_o = flat_map;

endmodule

//--- hdl/cpu_ram_mapper.sv
`include "coleco_consts.svh"

module cpu_ram_mapper
    import coleco_mem_pkg::*;
(
    input  logic               clk_sys,
    input  logic               reset,
    input  ram_req_t           cpu_req_i,
    input  logic               sg1000_i,
    input  ram_size_e          ram_size_i,
    input  logic               flat_map_i,
    output logic [`RAM_AW-1:0] ram_addr_o,
    output logic               ram_we_o
);

    logic [1:0]         clk_cnt;
    logic               cpu_ce;
    logic [`RAM_AW-1:0] a;

    // CPU runs at half the system clock
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            clk_cnt <= '0;
            cpu_ce  <= 1'b0;
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
            cpu_ce  <= clk_cnt[0];
        end
    end

    assign a = cpu_req_i.addr;

    always_comb begin
        if (sg1000_i && flat_map_i) begin
            ram_addr_o = a;
        end else if (sg1000_i && !a[14]) begin
            // 16k at 8000 for SG-1000 carts with extra RAM
            ram_addr_o = {1'b1, a[13:0]};
        end else if (ram_size_i == RAM_8K) begin
            ram_addr_o = {{(`RAM_AW - 13){1'b0}}, a[12:0]};
        end else if (ram_size_i == RAM_1K) begin
            ram_addr_o = {{(`RAM_AW - 10){1'b0}}, a[9:0]};
        end else if (sg1000_i) begin
            // SGM size means 16k on SG-1000
            ram_addr_o = {1'b0, a[13:0]};
        end else begin
            ram_addr_o = a;
        end
    end

    assign ram_we_o = cpu_ce & ~(cpu_req_i.ce_n | cpu_req_i.we_n);

endmodule

//--- hdl/coleco_ctrl_top.sv
`include "coleco_consts.svh"

module coleco_ctrl_top
    import coleco_ctrl_pkg::*;
    import coleco_mem_pkg::*;
#(
    parameter int spin_div_bits = `SPIN_DIV_BITS
) (
    input  logic               clk_sys,
    input  logic               reset,
    input  joy_word_t          joy0_i,
    input  joy_word_t          joy1_i,
    input  logic [15:0]        ps2_keys_i,
    input  logic [4:0]         ps2_joy_i,
    input  logic               joy_swap_i,
    input  logic               spinner_on_i,
    input  logic               sg1000_i,
    input  ram_size_e          ram_size_i,
    input  ctrl_sel_t [1:0]    sel_i,
    input  dl_write_t          dl_i,
    input  ram_req_t           cpu_req_i,
    output port_pins_t [1:0]   port_o,
    output logic [`RAM_AW-1:0] ram_addr_o,
    output logic               ram_we_o
);

    pad_in_t [1:0] pad;
    logic          flat_map;

    // ------------------------------------------------------------
    // Controller ports
    // ------------------------------------------------------------

    pad_input_stage #(
        .spin_div_bits (spin_div_bits)
    ) u_pad_input_stage (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .joy0_i     (joy0_i),
        .joy1_i     (joy1_i),
        .ps2_keys_i (ps2_keys_i),
        .ps2_joy_i  (ps2_joy_i),
        .joy_swap_i (joy_swap_i),
        .pad_o      (pad)
    );

    for (genvar i = 0; i < 2; i++) begin : g_port
        ctrl_port_encoder u_encoder (
            .clk_sys      (clk_sys),
            .reset        (reset),
            .pad_i        (pad[i]),
            .sel_i        (sel_i[i]),
            .spinner_on_i (spinner_on_i),
            .pins_o       (port_o[i])
        );
    end

    // ------------------------------------------------------------
    // Cartridge probe and CPU RAM
    // ------------------------------------------------------------

    sg_cart_probe u_sg_cart_probe (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .dl_i       (dl_i),
        .sg1000_i   (sg1000_i),
        .flat_map_o (flat_map)
    );

    cpu_ram_mapper u_cpu_ram_mapper (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .cpu_req_i  (cpu_req_i),
        .sg1000_i   (sg1000_i),
        .ram_size_i (ram_size_i),
        .flat_map_i (flat_map),
        .ram_addr_o (ram_addr_o),
        .ram_we_o   (ram_we_o)
    );

endmodule

//--- tests/tb_coleco_ctrl.sv
`include "coleco_consts.svh"

module tb_coleco_ctrl
    import coleco_ctrl_pkg::*;
    import coleco_mem_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    logic               clk_sys;
    logic               reset;
    joy_word_t          joy0;
    joy_word_t          joy1;
    logic [15:0]        ps2_keys;
    logic [4:0]         ps2_joy;
    logic               joy_swap;
    logic               spinner_on;
    logic               sg1000;
    ram_size_e          ram_size;
    ctrl_sel_t [1:0]    sel;
    dl_write_t          dl;
    ram_req_t           cpu_req;
    port_pins_t [1:0]   port;
    logic [`RAM_AW-1:0] ram_addr;
    logic               ram_we;
    logic [31:0]        rng_state;

    coleco_ctrl_top #(
        .spin_div_bits (4)
    ) dut (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .joy0_i       (joy0),
        .joy1_i       (joy1),
        .ps2_keys_i   (ps2_keys),
        .ps2_joy_i    (ps2_joy),
        .joy_swap_i   (joy_swap),
        .spinner_on_i (spinner_on),
        .sg1000_i     (sg1000),
        .ram_size_i   (ram_size),
        .sel_i        (sel),
        .dl_i         (dl),
        .cpu_req_i    (cpu_req),
        .port_o       (port),
        .ram_addr_o   (ram_addr),
        .ram_we_o     (ram_we)
    );

    initial begin
        clk_sys = 1'b0;
        forever #4 clk_sys = ~clk_sys;
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Inputs are driven 1 ns after the rising edge
    task automatic tick();
        @(posedge clk_sys);
        #1;
    endtask

    task automatic stop_on_error();
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic abort_run(input string why);
        $display("ERROR: %s", why);
        stop_on_error();
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
            stop_on_error();
        end
    endtask

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------

    // Key priority 1..9, 0, *, # from the ps2 key bits
    function automatic logic [3:0] keypad_code(input logic [15:0] k);
        if (k[13]) return 4'b1110;
        if (k[7])  return 4'b1101;
        if (k[12]) return 4'b0110;
        if (k[2])  return 4'b0001;
        if (k[3])  return 4'b1001;
        if (k[14]) return 4'b0111;
        if (k[5])  return 4'b1100;
        if (k[1])  return 4'b1000;
        if (k[11]) return 4'b1011;
        if (k[10]) return 4'b0011;
        if (k[9])  return 4'b1010;
        if (k[6])  return 4'b0101;
        return 4'b1111;
    endfunction

    // Full port pins with the spinner off
    function automatic logic [6:0] port_model(input int i);
        joy_word_t  j;
        logic [3:0] lines;
        logic       p6;
        j     = (joy_swap ^ (i == 1)) ? joy1 : joy0;
        lines = 4'b1111;
        p6    = 1'b1;
        if (!sel[i].p5 && sel[i].p8) begin
            lines = keypad_code(ps2_keys);
            p6    = ~(ps2_keys[0] | j.fire2);
        end else if (sel[i].p5 && !sel[i].p8) begin
            lines = {~(ps2_joy[0] | j.up), ~(ps2_joy[1] | j.down),
                     ~(ps2_joy[2] | j.left), ~(ps2_joy[3] | j.right)};
            p6    = ~(ps2_joy[4] | j.fire1);
        end
        return {lines, p6, 2'b11};
    endfunction

    function automatic logic [1:0] spin_next(input logic [1:0] q, input logic left);
        logic [1:0] nxt;
        if (left) begin
            case (q)
                2'b00:   nxt = 2'b01;
                2'b01:   nxt = 2'b11;
                2'b11:   nxt = 2'b10;
                default: nxt = 2'b00;
            endcase
        end else begin
            case (q)
                2'b00:   nxt = 2'b10;
                2'b10:   nxt = 2'b11;
                2'b11:   nxt = 2'b01;
                default: nxt = 2'b00;
            endcase
        end
        return nxt;
    endfunction

    // Ordered RAM map rules
    function automatic logic [`RAM_AW-1:0] mapped_addr(input logic [`RAM_AW-1:0] a,
            input logic sg, input logic flat, input logic [1:0] size);
        if (sg && flat) return a;
        if (sg && !a[14]) return {1'b1, a[13:0]};
        if (size == 2'd1) return {2'b00, a[12:0]};
        if (size == 2'd0) return {5'b00000, a[9:0]};
        if (sg) return {1'b0, a[13:0]};
        return a;
    endfunction

    // ------------------------------------------------------------
    // Test sequences
    // ------------------------------------------------------------

    task automatic run_pad_trials(input int count, input bit keypad_only);
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        for (int k = 0; k < count; k++) begin
            r0 = next_rand();
            r1 = next_rand();
            r2 = next_rand();
            joy0     = r0[7:0];
            joy1     = r0[15:8];
            ps2_keys = r1[15:0] & r1[31:16] & r2[15:0];
            ps2_joy  = r2[20:16] & r0[20:16];
            joy_swap = r2[31];
            if (keypad_only) begin
                sel[0] = '{p5: 1'b0, p8: 1'b1};
                sel[1] = '{p5: 1'b0, p8: 1'b1};
            end else begin
                sel = r0[27:24];
            end
            tick();
            tick();
            check_value("port_o[0]", 32'(port[0]), 32'(port_model(0)));
            check_value("port_o[1]", 32'(port[1]), 32'(port_model(1)));
        end
    endtask

    // Port 0 gets the left joystick unless swapped
    task automatic run_spinner(input int moves);
        logic [1:0] prev [2];
        logic [1:0] cur;
        logic       lft [2];
        bit         moved [2];
        int         n;
        for (int p = 0; p < 2; p++) begin
            prev[p] = {port[p].p7, port[p].p9};
            lft[p]  = !(joy_swap ^ (p == 1));
        end
        for (int m = 0; m < moves; m++) begin
            n        = 0;
            moved[0] = 1'b0;
            moved[1] = 1'b0;
            while (!(moved[0] && moved[1])) begin
                if (n == 40) abort_run("spinner pins did not change within 40 cycles");
                tick();
                n++;
                for (int p = 0; p < 2; p++) begin
                    cur = {port[p].p7, port[p].p9};
                    if (cur != prev[p]) begin
                        check_value($sformatf("port_o[%0d] p7/p9", p), 32'(cur),
                                    32'(spin_next(prev[p], lft[p])));
                        moved[p] = 1'b1;
                    end
                    prev[p] = cur;
                end
            end
        end
    endtask

    // Bytes outside 2xxx-3xxx are written too and must be ignored
    task automatic download_cart(input logic [15:0] bad_addr, input bit all_ff,
                                 output logic flat);
        logic [31:0] r;
        logic [7:0]  chk;
        chk       = 8'h00;
        dl        = '0;
        dl.active = 1'b1;
        tick();
        for (int k = 0; k < 16; k++) begin
            r       = next_rand();
            dl.wr   = 1'b1;
            dl.addr = {1'b1, r[14:0]};
            dl.data = 8'h00;
            tick();
        end
        for (int a = 16'h2000; a < 16'h4000; a++) begin
            r       = next_rand();
            dl.wr   = 1'b1;
            dl.addr = 16'(a);
            dl.data = (!all_ff && dl.addr == bad_addr) ? (r[7:0] & 8'hF7) : 8'hFF;
            chk     = (a == 16'h2000) ? dl.data : (chk & dl.data);
            tick();
        end
        dl.wr = 1'b0;
        tick();
        dl.active = 1'b0;
        tick();
        tick();
        flat = (chk == 8'hFF);
    endtask

    task automatic probe_map_check(input logic flat);
        logic [31:0] r;
        for (int k = 0; k < 20; k++) begin
            r            = next_rand();
            cpu_req.addr = {1'b0, r[13:0]};
            ram_size     = ram_size_e'(r[17:16]);
            tick();
            tick();
            check_value("ram_addr_o", 32'(ram_addr),
                        32'(mapped_addr(cpu_req.addr, 1'b1, flat, r[17:16])));
        end
    endtask

    task automatic run_ram_map(input int count);
        logic [31:0] r;
        for (int k = 0; k < count; k++) begin
            r            = next_rand();
            cpu_req.addr = r[14:0];
            ram_size     = ram_size_e'(r[16:15]);
            sg1000       = r[17];
            tick();
            tick();
            check_value("ram_addr_o", 32'(ram_addr),
                        32'(mapped_addr(r[14:0], r[17], 1'b0, r[16:15])));
        end
    endtask

    // Outputs are sampled before the next inputs are driven
    task automatic check_write_gating(input int cycles);
        logic [31:0] r;
        logic        prev_we;
        int          n;
        prev_we = 1'b0;
        for (int k = 0; k < cycles; k++) begin
            tick();
            if (ram_we && (cpu_req.ce_n || cpu_req.we_n))
                abort_run("ram_we_o high without an active write request");
            if (ram_we && prev_we)
                abort_run("ram_we_o high on two consecutive cycles");
            prev_we = ram_we;
            r = next_rand();
            cpu_req.ce_n = r[0] & r[2];
            cpu_req.we_n = r[1] & r[3];
        end
        cpu_req.ce_n = 1'b0;
        cpu_req.we_n = 1'b0;
        tick();
        n = 1;
        while (!ram_we) begin
            if (n >= 2) abort_run("ram_we_o did not rise within 2 cycles of a write");
            tick();
            n++;
        end
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------

    initial begin
        logic flat;
        rng_state  = 32'h48b9;
        reset      = 1'b1;
        joy0       = '0;
        joy1       = '0;
        ps2_keys   = '0;
        ps2_joy    = '0;
        joy_swap   = 1'b0;
        spinner_on = 1'b0;
        sg1000     = 1'b0;
        ram_size   = RAM_1K;
        sel        = '0;
        dl         = '0;
        cpu_req    = '{addr: '0, ce_n: 1'b1, we_n: 1'b1};
        repeat (5) @(posedge clk_sys);
        #1;
        reset = 1'b0;
        check_value("ram_we_o", 32'(ram_we), 32'h0);
        check_value("port_o[0] p7/p9", 32'({port[0].p7, port[0].p9}), 32'h3);
        check_value("port_o[1] p7/p9", 32'({port[1].p7, port[1].p9}), 32'h3);

        run_pad_trials(200, 1'b1);
        run_pad_trials(300, 1'b0);

        // Left held on joy0, right on joy1
        ps2_keys = '0;
        ps2_joy  = '0;
        sel      = '0;
        joy0     = '{left: 1'b1, default: 1'b0};
        joy1     = '{right: 1'b1, default: 1'b0};
        for (int s = 0; s < 2; s++) begin
            joy_swap = s[0];
            tick();
            spinner_on = 1'b1;
            tick();
            tick();
            run_spinner(6);
            spinner_on = 1'b0;
            tick();
            tick();
            check_value("port_o[0] p7/p9", 32'({port[0].p7, port[0].p9}), 32'h3);
            check_value("port_o[1] p7/p9", 32'({port[1].p7, port[1].p9}), 32'h3);
        end

        sg1000 = 1'b1;
        download_cart(16'h0000, 1'b1, flat);
        probe_map_check(flat);
        download_cart(16'h2000 + 16'(next_rand() & 32'h1FFF), 1'b0, flat);
        probe_map_check(flat);

        run_ram_map(300);
        check_write_gating(200);

        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- sim.f
+incdir+hdl
hdl/coleco_ctrl_pkg.sv
hdl/coleco_mem_pkg.sv
hdl/pad_input_stage.sv
hdl/ctrl_port_encoder.sv
hdl/sg_cart_probe.sv
hdl/cpu_ram_mapper.sv
hdl/coleco_ctrl_top.sv
tests/tb_coleco_ctrl.sv

//--- Makefile
# Verilator build of the controller and cartridge glue testbench
SIM := obj_dir/Vtb_coleco_ctrl

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): sim.f $(wildcard hdl/*.sv hdl/*.svh tests/*.sv)
	verilator --binary --timing --top-module tb_coleco_ctrl -f sim.f

run: $(SIM)
	-./$(SIM) > sim.log 2>&1
	@cat sim.log
	@if grep -q "=== FAIL ===" sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" sim.log; then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
